// ==== design/spi_frame_pkg.sv ====
/* SPI frame field types, command codes and the peripheral FSM phases */
package spi_frame_pkg;

	// field order on the wire: command, address, data
	typedef logic [7:0]  spi_cmd_t;
	typedef logic [15:0] spi_addr_t;
	typedef logic [31:0] spi_word_t;

	// store the data field
	localparam spi_cmd_t CMD_WRITE = 8'h57;
	// read only, memory untouched
	localparam spi_cmd_t CMD_READ = 8'h52;

	// 8 + 16 + 32 = 56 rising sck edges per frame
	localparam int FRAME_BITS = $bits(spi_cmd_t) + $bits(spi_addr_t) + $bits(spi_word_t);

	// idle waits for ssel low, shift counts edges,
	// commit is the write cycle, done waits for ssel high
	typedef enum logic [1:0] {
		idle,
		shift,
		commit,
		done
	} spi_phase_t;

endpackage

// ==== design/mem_pkg.sv ====
/* memory byte and word types, byte lane count and default depth */
package mem_pkg;

	// one byte lane
	typedef logic [7:0] byte_t;

	localparam int LANES = 4;

	// lane 0 sits in bits 7:0
	typedef logic [LANES*$bits(byte_t)-1:0] mem_word_t;

	// 64 words of 32 bits
	localparam int DEFAULT_ADDR_WIDTH = 6;

endpackage

// ==== design/spi_peripheral.sv ====
`timescale 1ns/1ps
/* oversampled SPI mode-0 peripheral for command/address/data frames
   writes through memory port A and returns the addressed word on miso */
module spi_peripheral #(
	parameter int ADDR_WIDTH = mem_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  clock50,
	input  logic                  reset3,
	input  logic                  sck,
	input  logic                  mosi,
	input  logic                  ssel,
	output logic                  miso,
	output logic [ADDR_WIDTH-1:0] a_addr,
	output mem_pkg::mem_word_t    a_wdata,
	output logic                  a_we,
	input  mem_pkg::mem_word_t    a_rdata
);
	import spi_frame_pkg::*;
	import mem_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BITS + 2);
	localparam int HDR_BITS = $bits(spi_cmd_t) + $bits(spi_addr_t);
	localparam int WORD_BITS = $bits(spi_word_t);
	localparam int BYTE_W = $bits(byte_t);

	logic [2:0] sck_sync;
	logic [1:0] ssel_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	logic ssel_high;

	spi_phase_t phase;
	logic [CNT_W-1:0] bit_count;
	logic frame_rise;
	logic frame_fall;
	logic hdr_done;
	logic frame_ok;
	logic data_phase;

	logic [WORD_BITS-1:0] shift_in;
	logic [WORD_BITS-1:0] shift_next;
	spi_cmd_t cmd;
	spi_addr_t addr_field;
	spi_word_t data_field;
	spi_word_t shift_out;
	logic cmd_known;
	logic [1:0] load_pipe;

	// first byte on the wire is lane 0
	function automatic mem_word_t swap_lanes(input mem_word_t w);
		mem_word_t r;
		for (int i = 0; i < LANES; i++) begin
			r[i*BYTE_W +: BYTE_W] = w[(LANES-1-i)*BYTE_W +: BYTE_W];
		end
		return r;
	endfunction

	always_ff @(posedge clock50) begin
		if (reset3) begin
			sck_sync <= '0;
			ssel_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			ssel_sync <= {ssel_sync[0], ssel};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sck_rise = sck_sync[2:1] == 2'b01;
	assign sck_fall = sck_sync[2:1] == 2'b10;
	assign ssel_high = ssel_sync[1];

	assign frame_rise = phase == shift && !ssel_high && sck_rise;
	assign frame_fall = phase == shift && !ssel_high && sck_fall;
	assign hdr_done = frame_rise && bit_count == CNT_W'(HDR_BITS - 1);
	assign frame_ok = bit_count == CNT_W'(FRAME_BITS);
	assign data_phase = bit_count >= CNT_W'(HDR_BITS);

	assign shift_next = {shift_in[WORD_BITS-2:0], mosi_sync[1]};
	assign addr_field = shift_next[$bits(spi_addr_t)-1:0];
	assign data_field = shift_in;
	assign cmd_known = cmd == CMD_WRITE || cmd == CMD_READ;

	always_ff @(posedge clock50) begin
		if (reset3) begin
			phase <= idle;
			bit_count <= '0;
			load_pipe <= '0;
			a_we <= 1'b0;
			miso <= 1'b0;
		end else begin
			// address registered, then memory read, then load
			load_pipe <= {load_pipe[0], hdr_done};
			a_we <= 1'b0;
			case (phase)
				idle: begin
					bit_count <= '0;
					miso <= 1'b0;
					if (!ssel_high) begin
						phase <= shift;
					end
				end
				shift: begin
					if (ssel_high) begin
						// short or long frames are dropped here
						if (frame_ok) begin
							a_we <= cmd == CMD_WRITE;
							phase <= commit;
						end else begin
							phase <= done;
						end
					end else begin
						// saturate one past a full frame
						if (sck_rise && bit_count != CNT_W'(FRAME_BITS + 1)) begin
							bit_count <= bit_count + 1'b1;
						end
						if (sck_fall && data_phase) begin
							miso <= shift_out[WORD_BITS-1];
						end
					end
				end
				commit: begin
					phase <= done;
				end
				done: begin
					miso <= 1'b0;
					if (ssel_high) begin
						phase <= idle;
					end
				end
				default: begin
					phase <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock50) begin
		if (frame_rise) begin
			shift_in <= shift_next;
		end
		if (hdr_done) begin
			cmd <= shift_next[HDR_BITS-1 -: $bits(spi_cmd_t)];
			a_addr <= addr_field[ADDR_WIDTH-1:0];
		end
		// unknown commands answer with zeros
		if (load_pipe[1]) begin
			shift_out <= cmd_known ? swap_lanes(a_rdata) : '0;
		end else if (frame_fall && data_phase) begin
			shift_out <= {shift_out[WORD_BITS-2:0], 1'b0};
		end
		if (phase == shift && ssel_high && frame_ok) begin
			a_wdata <= swap_lanes(data_field);
		end
	end

endmodule

// ==== design/pollable_memory.sv ====
`timescale 1ns/1ps
/* dual-port word memory with a 32-bit read/write port A
   and a byte-wide read-only port B, both registered */
module pollable_memory #(
	parameter int ADDR_WIDTH = mem_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  clock50,
	input  logic [ADDR_WIDTH-1:0] a_addr,
	input  mem_pkg::mem_word_t    a_wdata,
	input  logic                  a_we,
	output mem_pkg::mem_word_t    a_rdata,
	input  logic [ADDR_WIDTH+1:0] b_addr,
	output mem_pkg::byte_t        b_rdata
);
	import mem_pkg::*;

	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam int LANE_W = $clog2(LANES);
	localparam int BYTE_W = $bits(byte_t);

	mem_word_t mem [DEPTH];

	logic [ADDR_WIDTH-1:0] b_word_addr;
	logic [LANE_W-1:0] b_lane;
	mem_word_t b_word;
	logic [LANE_W-1:0] b_lane_q;

	// byte address k is lane k mod 4 of word k div 4
	assign b_word_addr = b_addr[ADDR_WIDTH+LANE_W-1:LANE_W];
	assign b_lane = b_addr[LANE_W-1:0];

	// port A, write-first
	always_ff @(posedge clock50) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
			a_rdata <= a_wdata;
		end else begin
			a_rdata <= mem[a_addr];
		end
	end

	// port B, full word read plus registered lane select
	always_ff @(posedge clock50) begin
		b_word <= mem[b_word_addr];
		b_lane_q <= b_lane;
	end

	assign b_rdata = b_word[b_lane_q*BYTE_W +: BYTE_W];

endmodule

// ==== design/waveform_player.sv ====
`timescale 1ns/1ps
/* free-running byte reader and MSB-first serializer
   with a byte 0 frame marker and the current byte on the LEDs */
module waveform_player #(
	parameter int ADDR_WIDTH = mem_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  clock50,
	input  logic                  reset3,
	output logic [ADDR_WIDTH+1:0] b_addr,
	input  mem_pkg::byte_t        b_rdata,
	output logic                  serial_out,
	output logic                  frame_start,
	output mem_pkg::byte_t        leds
);
	import mem_pkg::*;

	localparam int BYTE_W = $bits(byte_t);
	localparam int SLOT_W = $clog2(BYTE_W);

	logic [SLOT_W-1:0] slot_bit;
	logic slot_end;
	byte_t shifter;

	assign slot_end = slot_bit == SLOT_W'(BYTE_W - 1);

	// MSB of the shifter is the line
	assign serial_out = shifter[BYTE_W-1];

	// b_addr already points at the next byte, so b_rdata
	// has settled long before the slot ends
	always_ff @(posedge clock50) begin
		if (reset3) begin
			slot_bit <= '0;
			b_addr <= '0;
			shifter <= '0;
			leds <= '0;
			frame_start <= 1'b0;
		end else begin
			slot_bit <= slot_bit + 1'b1;
			frame_start <= slot_end && b_addr == '0;
			if (slot_end) begin
				shifter <= b_rdata;
				leds <= b_rdata;
				// wraps to byte 0 after the last lane
				b_addr <= b_addr + 1'b1;
			end else begin
				shifter <= {shifter[BYTE_W-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== design/spi_pollable_memory_top.sv ====
`timescale 1ns/1ps
/* top level with the SPI peripheral, the pollable memory and the waveform player */
module spi_pollable_memory_top #(
	parameter int ADDR_WIDTH = mem_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic           clock50,
	input  logic           reset3,
	input  logic           sck,
	input  logic           mosi,
	input  logic           ssel,
	output logic           miso,
	output logic           serial_out,
	output logic           frame_start,
	output mem_pkg::byte_t leds
);
	import mem_pkg::*;

	// port A, SPI side
	logic [ADDR_WIDTH-1:0] a_addr;
	mem_word_t a_wdata;
	logic a_we;
	mem_word_t a_rdata;

	// port B, playback side
	logic [ADDR_WIDTH+1:0] b_addr;
	byte_t b_rdata;

	spi_peripheral #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_spi (
		.clock50(clock50),
		.reset3(reset3),
		.sck(sck),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.a_addr(a_addr),
		.a_wdata(a_wdata),
		.a_we(a_we),
		.a_rdata(a_rdata)
	);

	pollable_memory #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_mem (
		.clock50(clock50),
		.a_addr(a_addr),
		.a_wdata(a_wdata),
		.a_we(a_we),
		.a_rdata(a_rdata),
		.b_addr(b_addr),
		.b_rdata(b_rdata)
	);

	waveform_player #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_player (
		.clock50(clock50),
		.reset3(reset3),
		.b_addr(b_addr),
		.b_rdata(b_rdata),
		.serial_out(serial_out),
		.frame_start(frame_start),
		.leds(leds)
	);

endmodule

// ==== dv/spi_pollable_memory_tb.sv ====
`timescale 1ns/1ps
/* SPI pollable memory testbench with an SPI host driver, a table of frames
   and serial stream and LED checks against a memory model */
module spi_pollable_memory_tb;
	import spi_frame_pkg::*;
	import mem_pkg::*;

	localparam int ADDR_WIDTH = 3;
	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam int NUM_BYTES = DEPTH * LANES;
	localparam int BYTE_W = $bits(byte_t);
	localparam int WORD_W = $bits(spi_word_t);
	localparam int HDR_BITS = $bits(spi_cmd_t) + $bits(spi_addr_t);
	localparam int ABORT_EDGES = 40;
	localparam int HALF_SCK = 4;
	localparam int FRAME_GAP = 8;
	localparam int START_TIMEOUT = NUM_BYTES * BYTE_W + 4 * BYTE_W;
	localparam logic [31:0] SEED = 32'h152d6553;

	logic clock50;
	logic reset3;
	logic sck;
	logic mosi;
	logic ssel;
	logic miso;
	logic serial_out;
	logic frame_start;
	byte_t leds;

	// frame table
	string tbl_name[$];
	spi_cmd_t tbl_cmd[$];
	spi_addr_t tbl_addr[$];
	spi_word_t tbl_data[$];
	bit tbl_abort[$];
	bit tbl_check[$];
	spi_word_t tbl_miso[$];

	// expected memory, words kept in wire order
	spi_word_t model [DEPTH];
	bit model_known [DEPTH];

	int errors = 0;
	int tests = 0;
	int failed = 0;

	spi_pollable_memory_top #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) uut (
		.clock50(clock50),
		.reset3(reset3),
		.sck(sck),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.serial_out(serial_out),
		.frame_start(frame_start),
		.leds(leds)
	);

	always #50 clock50 = ~clock50;

	function automatic void add_frame(input string name, input spi_cmd_t cmd,
			input spi_addr_t addr, input spi_word_t data, input bit abort);
		int idx;
		bit known_cmd;
		idx = addr % DEPTH;
		known_cmd = cmd == CMD_WRITE || cmd == CMD_READ;
		tbl_name.push_back(name);
		tbl_cmd.push_back(cmd);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
		tbl_abort.push_back(abort);
		// miso carries the old word or zeros for a foreign command
		tbl_check.push_back(!abort && (!known_cmd || model_known[idx]));
		tbl_miso.push_back(known_cmd ? model[idx] : '0);
		if (cmd == CMD_WRITE && !abort) begin
			model[idx] = data;
			model_known[idx] = 1'b1;
		end
	endfunction

	function automatic byte_t model_byte(input int k);
		spi_word_t w;
		int lane;
		w = model[(k / LANES) % DEPTH];
		lane = k % LANES;
		// lane 0 was the first byte on the wire
		return w[WORD_W-1-lane*BYTE_W -: BYTE_W];
	endfunction

	task automatic build_table();
		for (int a = 0; a < DEPTH; a++) begin
			add_frame($sformatf("wr_a%0d", a), CMD_WRITE, spi_addr_t'(a), $urandom(), 1'b0);
			add_frame($sformatf("rd_a%0d", a), CMD_READ, spi_addr_t'(a), $urandom(), 1'b0);
		end
		add_frame("alias_wr_11", CMD_WRITE, 16'd11, $urandom(), 1'b0);
		add_frame("alias_rd_3", CMD_READ, 16'd3, 32'h0, 1'b0);
		add_frame("alias_wr_fffd", CMD_WRITE, 16'hfffd, $urandom(), 1'b0);
		add_frame("alias_rd_5", CMD_READ, 16'd5, 32'h0, 1'b0);
		add_frame("unk_cmd_a5", 8'ha5, 16'd2, $urandom(), 1'b0);
		add_frame("unk_rd_2", CMD_READ, 16'd2, 32'h0, 1'b0);
		add_frame("unk_cmd_00", 8'h00, 16'd7, $urandom(), 1'b0);
		add_frame("unk_rd_7", CMD_READ, 16'd7, 32'h0, 1'b0);
		add_frame("abort_wr_6", CMD_WRITE, 16'd6, $urandom(), 1'b1);
		add_frame("abort_rd_6", CMD_READ, 16'd6, 32'h0, 1'b0);
	endtask

	task automatic compare_word(input string name, input spi_word_t expected,
			input spi_word_t actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s ok", name);
		end else begin
			failed++;
			$display("test %s FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic end_run();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// mode 0 host that sets data while sck is low and samples miso before each rise
	task automatic spi_frame(input spi_cmd_t cmd, input spi_addr_t addr,
			input spi_word_t data, input int edges, output spi_word_t rx);
		logic [FRAME_BITS-1:0] tx;
		tx = {cmd, addr, data};
		rx = '0;
		ssel = 1'b0;
		for (int i = 0; i < edges; i++) begin
			mosi = tx[FRAME_BITS-1-i];
			repeat (HALF_SCK) @(negedge clock50);
			if (i >= HDR_BITS) begin
				rx = {rx[WORD_W-2:0], miso};
			end
			sck = 1'b1;
			repeat (HALF_SCK) @(negedge clock50);
			sck = 1'b0;
		end
		mosi = 1'b0;
		repeat (HALF_SCK) @(negedge clock50);
		ssel = 1'b1;
		repeat (FRAME_GAP) @(negedge clock50);
	endtask

	task automatic wait_frame_start(input string name, output bit seen);
		int n;
		n = 0;
		while (frame_start !== 1'b1 && n < START_TIMEOUT) begin
			@(negedge clock50);
			n++;
		end
		seen = frame_start === 1'b1;
		if (!seen) begin
			$display("%s: frame_start did not appear within %0d cycles", name, START_TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_serial_stream();
		byte_t shifted;
		int start_errors;
		bit seen;
		start_errors = errors;
		shifted = '0;
		wait_frame_start("play_serial", seen);
		if (seen) begin
			// one byte past the end to see the wrap
			for (int i = 0; i < (NUM_BYTES + 1) * BYTE_W; i++) begin
				shifted = {shifted[BYTE_W-2:0], serial_out};
				if (i % BYTE_W == BYTE_W - 1) begin
					compare_byte($sformatf("play_serial[%0d]", i / BYTE_W),
						model_byte((i / BYTE_W) % NUM_BYTES), shifted);
				end
				@(negedge clock50);
			end
		end
		report_test("play_serial", start_errors);
	endtask

	task automatic check_led_bytes();
		int start_errors;
		bit seen;
		start_errors = errors;
		wait_frame_start("play_leds", seen);
		if (seen) begin
			for (int b = 0; b <= NUM_BYTES; b++) begin
				if (b == NUM_BYTES && frame_start !== 1'b1) begin
					$display("play_leds: frame_start missing when the stream wrapped to byte 0");
					errors++;
				end
				compare_byte($sformatf("play_leds[%0d]", b), model_byte(b % NUM_BYTES), leds);
				// next slot boundary
				repeat (BYTE_W) @(negedge clock50);
			end
		end
		report_test("play_leds", start_errors);
	endtask

	initial begin
		spi_word_t rx;
		int start_errors;
		clock50 = 1'b0;
		reset3 = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		ssel = 1'b1;
		void'($urandom(SEED));
		build_table();
		repeat (8) @(negedge clock50);
		reset3 = 1'b0;
		repeat (4) @(negedge clock50);
		for (int t = 0; t < tbl_name.size(); t++) begin
			start_errors = errors;
			spi_frame(tbl_cmd[t], tbl_addr[t], tbl_data[t],
				tbl_abort[t] ? ABORT_EDGES : FRAME_BITS, rx);
			if (tbl_check[t]) begin
				compare_word(tbl_name[t], tbl_miso[t], rx);
			end
			report_test(tbl_name[t], start_errors);
		end
		check_serial_stream();
		check_led_bytes();
		end_run();
	end

endmodule

// ==== spi_pollable_memory.f ====
design/spi_frame_pkg.sv
design/mem_pkg.sv
design/spi_peripheral.sv
design/pollable_memory.sv
design/waveform_player.sv
design/spi_pollable_memory_top.sv
dv/spi_pollable_memory_tb.sv

// ==== Bender.yml ====
package:
  name: spi_pollable_memory

sources:
  - files:
      - design/spi_frame_pkg.sv
      - design/mem_pkg.sv
      - design/spi_peripheral.sv
      - design/pollable_memory.sv
      - design/waveform_player.sv
      - design/spi_pollable_memory_top.sv
  - target: test
    files:
      - dv/spi_pollable_memory_tb.sv
